/* Bender.yml */
package:
  name: vlane_cluster

sources:
  - include_dirs:
      - design
    files:
      - design/vlane_pkg.sv
      - design/vlane_csr_apb.sv
      - design/lane_operand_gather.sv
      - design/lane_simd_alu.sv
      - design/result_scatter_slide.sv
      - design/vlane_cluster_top.sv
  - target: test
    include_dirs:
      - design
      - verification
    files:
      - verification/tb_vlane_cluster.sv

/* design/lane_operand_gather.sv */
`timescale 1ns/1ps
`include "vlane_cfg.svh"

module lane_operand_gather
(
   input  logic                                   clk_i,
   input  logic                                   rst_i,
   input  logic                                   valid_i,
   input  vlane_pkg::lane_word_u [`VLANE_NUM-1:0] vs1_i,
   input  vlane_pkg::lane_word_u [`VLANE_NUM-1:0] vs2_i,
   input  vlane_pkg::alu_op_e                     cfg_op_i,
   input  vlane_pkg::sew_e                        cfg_sew_i,
   input  vlane_pkg::op2_src_e                    cfg_src_i,
   input  logic [31:0]                            cfg_x_i,
   input  logic [4:0]                             cfg_imm_i,
   input  logic                                   cfg_slide_en_i,
   input  logic                                   cfg_slide_dn_i,
   input  logic [2:0]                             cfg_slide_amt_i,
   output vlane_pkg::lane_word_u [`VLANE_NUM-1:0] a_o,
   output vlane_pkg::lane_word_u [`VLANE_NUM-1:0] b_o,
   output vlane_pkg::alu_op_e                     op_o,
   output vlane_pkg::sew_e                        sew_o,
   output logic                                   slide_en_o,
   output logic                                   slide_dn_o,
   output logic [2:0]                             slide_amt_o,
   output logic                                   valid_o
);

   import vlane_pkg::*;

   localparam int N  = `VLANE_NUM;
   localparam int NB = `LANE_W / 8;

   typedef lane_word_u [N-1:0] lane_vec_t;

   lane_vec_t   a_d;
   lane_vec_t   b_d;
   lane_vec_t   vs2_d;
   logic [31:0] x_rep;
   logic [31:0] imm_rep;

   // Slot s = h*G + m holds group m of byte row h, G = N/eb
   // Byte k of a slot comes from lane eb*m + k%eb, row h + eb*(k/eb)
   function automatic lane_vec_t gather(input lane_vec_t vs, input int eb);
      lane_vec_t slots;
      int        g;
      int        lane;
      int        row;
      g = N / eb;
      for (int s = 0; s < N; s++)
      begin
         for (int k = 0; k < NB; k++)
         begin
            lane = eb * (s % g) + k % eb;
            row  = s / g + eb * (k / eb);
            slots[s].bytes[k] = vs[lane].bytes[row];
         end
      end
      return slots;
   endfunction

   always_comb
   begin
      case (cfg_sew_i)
         SEW16:
         begin
            a_d     = gather(vs1_i, 2);
            vs2_d   = gather(vs2_i, 2);
            x_rep   = {2{cfg_x_i[15:0]}};
            imm_rep = {2{{11{cfg_imm_i[4]}}, cfg_imm_i}};
         end
         SEW32:
         begin
            a_d     = gather(vs1_i, 4);
            vs2_d   = gather(vs2_i, 4);
            x_rep   = cfg_x_i;
            imm_rep = {{27{cfg_imm_i[4]}}, cfg_imm_i};
         end
         default:                                       // SEW8 and reserved
         begin
            a_d     = vs1_i;
            vs2_d   = vs2_i;
            x_rep   = {4{cfg_x_i[7:0]}};
            imm_rep = {4{{3{cfg_imm_i[4]}}, cfg_imm_i}};
         end
      endcase

      case (cfg_src_i)
         XDATA:   b_d = {N{x_rep}};
         IMM:     b_d = {N{imm_rep}};
         default: b_d = vs2_d;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         valid_o <= 1'b0;
      else
         valid_o <= valid_i;
   end

   // Configuration is captured with the item
   always_ff @(posedge clk_i)
   begin
      if (valid_i)
      begin
         a_o         <= a_d;
         b_o         <= b_d;
         op_o        <= cfg_op_i;
         sew_o       <= cfg_sew_i;
         slide_en_o  <= cfg_slide_en_i;
         slide_dn_o  <= cfg_slide_dn_i;
         slide_amt_o <= cfg_slide_amt_i;
      end
   end

endmodule

/* design/lane_simd_alu.sv */
`timescale 1ns/1ps
`include "vlane_cfg.svh"

module lane_simd_alu
(
   input  logic                                   clk_i,
   input  logic                                   rst_i,
   input  logic                                   valid_i,
   input  vlane_pkg::lane_word_u [`VLANE_NUM-1:0] a_i,
   input  vlane_pkg::lane_word_u [`VLANE_NUM-1:0] b_i,
   input  vlane_pkg::alu_op_e                     op_i,
   input  vlane_pkg::sew_e                        sew_i,
   input  logic                                   slide_en_i,
   input  logic                                   slide_dn_i,
   input  logic [2:0]                             slide_amt_i,
   output vlane_pkg::lane_word_u [`VLANE_NUM-1:0] res_o,
   output logic                                   valid_o,
   output logic                                   slide_en_o,
   output logic                                   slide_dn_o,
   output logic [2:0]                             slide_amt_o,
   output vlane_pkg::sew_e                        sew_o
);

   import vlane_pkg::*;

   localparam int N = `VLANE_NUM;

   lane_word_u [N-1:0] res_d;

   // Byte-wise ripple, carry reloaded at each element start
   function automatic logic [31:0] seg_add(input logic [31:0] a,
                                           input logic [31:0] b,
                                           input logic        sub,
                                           input sew_e        sew);
      logic [31:0] b_eff;
      logic [31:0] res;
      logic [8:0]  sum;
      logic        carry;
      logic        cut;
      b_eff = sub ? ~b : b;
      carry = sub;
      for (int k = 0; k < 4; k++)
      begin
         case (sew)
            SEW16:   cut = (k % 2 == 0);
            SEW32:   cut = (k == 0);
            default: cut = 1'b1;
         endcase
         if (cut)
            carry = sub;                               // Two's complement +1
         sum = {1'b0, a[8*k +: 8]} + {1'b0, b_eff[8*k +: 8]} + {8'd0, carry};
         res[8*k +: 8] = sum[7:0];
         carry = sum[8];
      end
      return res;
   endfunction

   always_comb
   begin
      for (int s = 0; s < N; s++)
      begin
         case (op_i)
            ADD:     res_d[s].word = seg_add(a_i[s].word, b_i[s].word, 1'b0, sew_i);
            SUB:     res_d[s].word = seg_add(a_i[s].word, b_i[s].word, 1'b1, sew_i);
            AND:     res_d[s].word = a_i[s].word & b_i[s].word;
            OR:      res_d[s].word = a_i[s].word | b_i[s].word;
            XOR:     res_d[s].word = a_i[s].word ^ b_i[s].word;
            default: res_d[s].word = '0;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         valid_o <= 1'b0;
      else
         valid_o <= valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (valid_i)
      begin
         res_o       <= res_d;
         sew_o       <= sew_i;
         slide_en_o  <= slide_en_i;
         slide_dn_o  <= slide_dn_i;
         slide_amt_o <= slide_amt_i;
      end
   end

endmodule

/* design/result_scatter_slide.sv */
`timescale 1ns/1ps
`include "vlane_cfg.svh"

module result_scatter_slide
(
   input  logic                                   clk_i,
   input  logic                                   rst_i,
   input  logic                                   valid_i,
   input  vlane_pkg::lane_word_u [`VLANE_NUM-1:0] res_i,
   input  vlane_pkg::sew_e                        sew_i,
   input  logic                                   slide_en_i,
   input  logic                                   slide_dn_i,
   input  logic [2:0]                             slide_amt_i,
   output vlane_pkg::lane_word_u [`VLANE_NUM-1:0] result_o,
   output logic                                   valid_o
);

   import vlane_pkg::*;

   localparam int N  = `VLANE_NUM;
   localparam int NB = `LANE_W / 8;

   typedef lane_word_u [N-1:0] lane_vec_t;

   lane_vec_t lanes_d;
   lane_vec_t slid_d;

   // Inverse of the gather map, slot byte back to lane and row
   function automatic lane_vec_t scatter(input lane_vec_t slots, input int eb);
      lane_vec_t lanes;
      int        g;
      int        lane;
      int        row;
      lanes = '0;
      g = N / eb;
      for (int s = 0; s < N; s++)
      begin
         for (int k = 0; k < NB; k++)
         begin
            lane = eb * (s % g) + k % eb;
            row  = s / g + eb * (k / eb);
            lanes[lane].bytes[row] = slots[s].bytes[k];
         end
      end
      return lanes;
   endfunction

   always_comb
   begin
      case (sew_i)
         SEW16:   lanes_d = scatter(res_i, 2);
         SEW32:   lanes_d = scatter(res_i, 4);
         default: lanes_d = res_i;
      endcase
   end

   ////////////////////
   // Lane rotate

   always_comb
   begin
      int src;
      for (int l = 0; l < N; l++)
      begin
         if (!slide_en_i)
            src = l;
         else if (slide_dn_i)
            src = (l + slide_amt_i) % N;               // Down takes from above
         else
            src = (l + N - slide_amt_i % N) % N;
         slid_d[l] = lanes_d[src];
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         valid_o <= 1'b0;
      else
         valid_o <= valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (valid_i)
         result_o <= slid_d;
   end

endmodule

/* design/vlane_cfg.svh */
`ifndef VLANE_CFG_SVH
`define VLANE_CFG_SVH

////////////////////
// Datapath geometry

`define VLANE_NUM 8    // Multiples of 4 also work
`define LANE_W    32

////////////////////
// APB register map

`define APB_AW    4
`define REG_CTRL  4'h0
`define REG_XDATA 4'h4
`define REG_IMM   4'h8

`endif

/* design/vlane_cluster_top.sv */
`timescale 1ns/1ps
`include "vlane_cfg.svh"

module vlane_cluster_top
(
   input  logic                                   clk_i,
   input  logic                                   rst_i,
   input  logic                                   psel_i,
   input  logic                                   penable_i,
   input  logic                                   pwrite_i,
   input  logic [`APB_AW-1:0]                     paddr_i,
   input  logic [31:0]                            pwdata_i,
   output logic [31:0]                            prdata_o,
   output logic                                   pready_o,
   output logic                                   pslverr_o,
   input  logic                                   valid_i,
   input  vlane_pkg::lane_word_u [`VLANE_NUM-1:0] vs1_i,
   input  vlane_pkg::lane_word_u [`VLANE_NUM-1:0] vs2_i,
   output vlane_pkg::lane_word_u [`VLANE_NUM-1:0] result_o,
   output logic                                   valid_o
);

   import vlane_pkg::*;

   // Register block to gather
   alu_op_e                     cfg_op;
   sew_e                        cfg_sew;
   op2_src_e                    cfg_src;
   logic [31:0]                 cfg_x;
   logic [4:0]                  cfg_imm;
   logic                        cfg_slide_en;
   logic                        cfg_slide_dn;
   logic [2:0]                  cfg_slide_amt;

   // Gather to ALU
   lane_word_u [`VLANE_NUM-1:0] g_a;
   lane_word_u [`VLANE_NUM-1:0] g_b;
   alu_op_e                     g_op;
   sew_e                        g_sew;
   logic                        g_slide_en;
   logic                        g_slide_dn;
   logic [2:0]                  g_slide_amt;
   logic                        g_valid;

   // ALU to scatter
   lane_word_u [`VLANE_NUM-1:0] alu_res;
   sew_e                        alu_sew;
   logic                        alu_slide_en;
   logic                        alu_slide_dn;
   logic [2:0]                  alu_slide_amt;
   logic                        alu_valid;

   vlane_csr_apb csr_inst
   (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .psel_i          (psel_i),
      .penable_i       (penable_i),
      .pwrite_i        (pwrite_i),
      .paddr_i         (paddr_i),
      .pwdata_i        (pwdata_i),
      .prdata_o        (prdata_o),
      .pready_o        (pready_o),
      .pslverr_o       (pslverr_o),
      .cfg_op_o        (cfg_op),
      .cfg_sew_o       (cfg_sew),
      .cfg_src_o       (cfg_src),
      .cfg_x_o         (cfg_x),
      .cfg_imm_o       (cfg_imm),
      .cfg_slide_en_o  (cfg_slide_en),
      .cfg_slide_dn_o  (cfg_slide_dn),
      .cfg_slide_amt_o (cfg_slide_amt)
   );

   lane_operand_gather gather_inst
   (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .valid_i         (valid_i),
      .vs1_i           (vs1_i),
      .vs2_i           (vs2_i),
      .cfg_op_i        (cfg_op),
      .cfg_sew_i       (cfg_sew),
      .cfg_src_i       (cfg_src),
      .cfg_x_i         (cfg_x),
      .cfg_imm_i       (cfg_imm),
      .cfg_slide_en_i  (cfg_slide_en),
      .cfg_slide_dn_i  (cfg_slide_dn),
      .cfg_slide_amt_i (cfg_slide_amt),
      .a_o             (g_a),
      .b_o             (g_b),
      .op_o            (g_op),
      .sew_o           (g_sew),
      .slide_en_o      (g_slide_en),
      .slide_dn_o      (g_slide_dn),
      .slide_amt_o     (g_slide_amt),
      .valid_o         (g_valid)
   );

   lane_simd_alu alu_inst
   (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .valid_i     (g_valid),
      .a_i         (g_a),
      .b_i         (g_b),
      .op_i        (g_op),
      .sew_i       (g_sew),
      .slide_en_i  (g_slide_en),
      .slide_dn_i  (g_slide_dn),
      .slide_amt_i (g_slide_amt),
      .res_o       (alu_res),
      .valid_o     (alu_valid),
      .slide_en_o  (alu_slide_en),
      .slide_dn_o  (alu_slide_dn),
      .slide_amt_o (alu_slide_amt),
      .sew_o       (alu_sew)
   );

   result_scatter_slide scatter_inst
   (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .valid_i     (alu_valid),
      .res_i       (alu_res),
      .sew_i       (alu_sew),
      .slide_en_i  (alu_slide_en),
      .slide_dn_i  (alu_slide_dn),
      .slide_amt_i (alu_slide_amt),
      .result_o    (result_o),
      .valid_o     (valid_o)
   );

endmodule

/* design/vlane_csr_apb.sv */
`timescale 1ns/1ps
`include "vlane_cfg.svh"

module vlane_csr_apb
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 psel_i,
   input  logic                 penable_i,
   input  logic                 pwrite_i,
   input  logic [`APB_AW-1:0]   paddr_i,
   input  logic [31:0]          pwdata_i,
   output logic [31:0]          prdata_o,
   output logic                 pready_o,
   output logic                 pslverr_o,
   output vlane_pkg::alu_op_e   cfg_op_o,
   output vlane_pkg::sew_e      cfg_sew_o,
   output vlane_pkg::op2_src_e  cfg_src_o,
   output logic [31:0]          cfg_x_o,
   output logic [4:0]           cfg_imm_o,
   output logic                 cfg_slide_en_o,
   output logic                 cfg_slide_dn_o,
   output logic [2:0]           cfg_slide_amt_o
);

   import vlane_pkg::*;

   // Op, sew, src, slide en/dn, slide amount
   localparam logic [31:0] CTRL_MASK = 32'h0007_3337;

   logic [31:0] ctrl_q;
   logic [31:0] xdata_q;
   logic [4:0]  imm_q;
   logic        sel_ctrl;
   logic        sel_xdata;
   logic        sel_imm;
   logic        addr_ok;
   logic        wr_en;

   assign sel_ctrl  = (paddr_i == `REG_CTRL);
   assign sel_xdata = (paddr_i == `REG_XDATA);
   assign sel_imm   = (paddr_i == `REG_IMM);
   assign addr_ok   = sel_ctrl | sel_xdata | sel_imm;
   assign wr_en     = psel_i & penable_i & pwrite_i & addr_ok;

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         ctrl_q  <= '0;
         xdata_q <= '0;
         imm_q   <= '0;
      end
      else if (wr_en)
      begin
         if (sel_ctrl)
            ctrl_q <= pwdata_i & CTRL_MASK;
         if (sel_xdata)
            xdata_q <= pwdata_i;
         if (sel_imm)
            imm_q <= pwdata_i[4:0];
      end
   end

   always_comb
   begin
      prdata_o = '0;
      if (sel_ctrl)
         prdata_o = ctrl_q;
      else if (sel_xdata)
         prdata_o = xdata_q;
      else if (sel_imm)
         prdata_o = {27'd0, imm_q};
   end

   assign pready_o  = 1'b1;                             // Zero wait states
   assign pslverr_o = psel_i & penable_i & ~addr_ok;

   ////////////////////
   // Field decode

   assign cfg_op_o        = alu_op_e'(ctrl_q[2:0]);
   assign cfg_sew_o       = sew_e'(ctrl_q[5:4]);
   assign cfg_src_o       = op2_src_e'(ctrl_q[9:8]);
   assign cfg_slide_en_o  = ctrl_q[12];
   assign cfg_slide_dn_o  = ctrl_q[13];                 // Lane L takes L+amount
   assign cfg_slide_amt_o = ctrl_q[18:16];
   assign cfg_x_o         = xdata_q;
   assign cfg_imm_o       = imm_q;

endmodule

/* design/vlane_pkg.sv */
`include "vlane_cfg.svh"

package vlane_pkg;

   // Element width, 3 decodes as SEW8
   typedef enum logic [1:0]
   {
      SEW8  = 2'd0,
      SEW16 = 2'd1,
      SEW32 = 2'd2
   } sew_e;

   typedef enum logic [2:0]
   {
      ADD = 3'd0,
      SUB = 3'd1,
      AND = 3'd2,
      OR  = 3'd3,
      XOR = 3'd4
   } alu_op_e;                      // 5 to 7 give zero

   typedef enum logic [1:0]
   {
      VEC   = 2'd0,
      XDATA = 2'd1,
      IMM   = 2'd2
   } op2_src_e;                     // 3 falls back to VEC

   // Whole word for the ALU, bytes for gather and scatter
   typedef union packed
   {
      logic [`LANE_W-1:0]        word;
      logic [`LANE_W/8-1:0][7:0] bytes;
   } lane_word_u;

endpackage

/* project.f */
+incdir+design
+incdir+verification
design/vlane_pkg.sv
design/vlane_csr_apb.sv
design/lane_operand_gather.sv
design/lane_simd_alu.sv
design/result_scatter_slide.sv
design/vlane_cluster_top.sv
verification/tb_vlane_cluster.sv

/* verification/tb_vlane_model.svh */
`ifndef TB_VLANE_MODEL_SVH
`define TB_VLANE_MODEL_SVH

// Reserved width counts as single bytes
function automatic int elem_bytes(input logic [1:0] sew);
   case (sew)
      2'd1:    return 2;
      2'd2:    return 4;
      default: return 1;
   endcase
endfunction

function automatic logic [31:0] elem_alu(input logic [2:0]  op,
                                         input logic [31:0] a,
                                         input logic [31:0] b,
                                         input logic [31:0] mask);
   case (op)
      3'd0:    return (a + b) & mask;
      3'd1:    return (a - b) & mask;
      3'd2:    return a & b;
      3'd3:    return a | b;
      3'd4:    return a ^ b;
      default: return '0;                               // Unused opcodes
   endcase
endfunction

// Group m of byte row b spans lanes eb*m to eb*m+eb-1
// Low byte comes from the lowest lane
function automatic lanes_t model_result(input lanes_t      vs1,
                                        input lanes_t      vs2,
                                        input logic [31:0] ctrl,
                                        input logic [31:0] x,
                                        input logic [4:0]  imm);
   lanes_t      res;
   lanes_t      out;
   int          eb;
   int          amt;
   logic [31:0] mask;
   logic [31:0] ea;
   logic [31:0] ev;
   logic [31:0] op2;
   logic [31:0] er;
   eb   = elem_bytes(ctrl[5:4]);
   mask = 32'((64'd1 << (8 * eb)) - 1);
   amt  = ctrl[18:16];
   for (int m = 0; m < `VLANE_NUM / eb; m++)
   begin
      for (int b = 0; b < 4; b++)
      begin
         ea = '0;
         ev = '0;
         for (int j = 0; j < eb; j++)
         begin
            ea[8*j +: 8] = vs1[eb*m + j][8*b +: 8];
            ev[8*j +: 8] = vs2[eb*m + j][8*b +: 8];
         end
         case (ctrl[9:8])
            2'd1:    op2 = x & mask;
            2'd2:    op2 = {{27{imm[4]}}, imm} & mask;  // Sign-extend then trim
            default: op2 = ev;
         endcase
         er = elem_alu(ctrl[2:0], ea, op2, mask);
         for (int j = 0; j < eb; j++)
            res[eb*m + j][8*b +: 8] = er[8*j +: 8];
      end
   end
   // Whole lane rotate
   for (int l = 0; l < `VLANE_NUM; l++)
   begin
      if (!ctrl[12])
         out[l] = res[l];
      else if (ctrl[13])
         out[l] = res[(l + amt) % `VLANE_NUM];
      else
         out[(l + amt) % `VLANE_NUM] = res[l];          // Lane L+amt takes lane L
   end
   return out;
endfunction

`endif

/* verification/tb_vlane_cluster.sv */
`timescale 1ns/1ps
`include "vlane_cfg.svh"

module tb_vlane_cluster;

   import vlane_pkg::*;

   typedef logic [`VLANE_NUM-1:0][`LANE_W-1:0] lanes_t;

   `include "tb_vlane_model.svh"

   // Roughly three times the stimulus length
   localparam int MAX_CYCLES = 2000;

   logic               clk_i;
   logic               rst_i;
   logic               psel_i;
   logic               penable_i;
   logic               pwrite_i;
   logic [`APB_AW-1:0] paddr_i;
   logic [31:0]        pwdata_i;
   logic [31:0]        prdata_o;
   logic               pready_o;
   logic               pslverr_o;
   logic               valid_i;
   lanes_t             vs1_i;
   lanes_t             vs2_i;
   lanes_t             result_o;
   logic               valid_o;

   integer      seed = 53;
   int          cycle_count = 0;
   int          items_sent = 0;
   int          items_checked = 0;
   logic [2:0]  valid_hist;
   lanes_t      exp_q[$];
   logic [31:0] shadow_ctrl = '0;                       // Mirrors the DUT registers
   logic [31:0] shadow_x = '0;
   logic [4:0]  shadow_imm = '0;

   vlane_cluster_top uut
   (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o),
      .valid_i   (valid_i),
      .vs1_i     (vs1_i),
      .vs2_i     (vs2_i),
      .result_o  (result_o),
      .valid_o   (valid_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever
         #10 clk_i = ~clk_i;
   end

   ////////////////////
   // Failure reporting

   task automatic report_failure(input string why);
      $display("ERROR: %s", why);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string                            name,
                                  input logic [`VLANE_NUM*`LANE_W-1:0] got,
                                  input logic [`VLANE_NUM*`LANE_W-1:0] exp);
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      $display("TB FAILED");
      $fatal(1);
   endtask

   function automatic logic [31:0] make_ctrl(input logic [2:0] op, input logic [1:0] sew,
                                             input logic [1:0] src, input logic en,
                                             input logic dn, input logic [2:0] amt);
      return {13'd0, amt, 2'd0, dn, en, 2'd0, src, 2'd0, sew, 1'b0, op};
   endfunction

   ////////////////////
   // APB and stream drivers

   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                            input logic exp_err);
      @(negedge clk_i);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b1;
      paddr_i   = addr;
      pwdata_i  = data;
      @(negedge clk_i);
      assert (pslverr_o === 1'b0) else report_mismatch("pslverr_o", pslverr_o, 1'b0);
      penable_i = 1'b1;
      @(posedge clk_i);                                 // Write lands on this edge
      case (addr)
         `REG_CTRL:  shadow_ctrl = data;
         `REG_XDATA: shadow_x = data;
         `REG_IMM:   shadow_imm = data[4:0];
         default:    ;
      endcase
      @(negedge clk_i);
      assert (pslverr_o === exp_err) else report_mismatch("pslverr_o", pslverr_o, exp_err);
      assert (pready_o === 1'b1) else report_mismatch("pready_o", pready_o, 1'b1);
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic apb_read(input logic [3:0] addr, input logic [31:0] exp_data,
                           input logic exp_err);
      @(negedge clk_i);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = addr;
      @(negedge clk_i);
      assert (pslverr_o === 1'b0) else report_mismatch("pslverr_o", pslverr_o, 1'b0);
      penable_i = 1'b1;
      @(negedge clk_i);
      assert (pslverr_o === exp_err) else report_mismatch("pslverr_o", pslverr_o, exp_err);
      assert (pready_o === 1'b1) else report_mismatch("pready_o", pready_o, 1'b1);
      if (!exp_err)
         assert (prdata_o === exp_data) else report_mismatch("prdata_o", prdata_o, exp_data);
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic random_lanes(output lanes_t v);
      for (int l = 0; l < `VLANE_NUM; l++)
         v[l] = $random(seed);
   endtask

   // Back-to-back items scored against the register mirror
   task automatic drive_burst(input int count);
      lanes_t v1;
      lanes_t v2;
      for (int i = 0; i < count; i++)
      begin
         @(negedge clk_i);
         random_lanes(v1);
         random_lanes(v2);
         vs1_i   = v1;
         vs2_i   = v2;
         valid_i = 1'b1;
         exp_q.push_back(model_result(v1, v2, shadow_ctrl, shadow_x, shadow_imm));
         items_sent++;
      end
      @(negedge clk_i);
      valid_i = 1'b0;
   endtask

   task automatic run_config(input logic [31:0] ctrl, input int count);
      apb_write(`REG_CTRL, ctrl, 1'b0);
      drive_burst(count);
   endtask

   ////////////////////
   // Monitors

   always @(posedge clk_i)
   begin
      if (!rst_i)
         valid_hist <= '0;
      else
         valid_hist <= {valid_hist[1:0], valid_i};
   end

   always @(posedge clk_i)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= MAX_CYCLES)
         report_failure("timeout, the run did not finish within the cycle limit");
   end

   // Scoreboard and latency check
   always @(negedge clk_i)
   begin
      lanes_t exp_v;
      if (rst_i === 1'b1)
      begin
         assert (valid_o === valid_hist[2])
         else report_mismatch("valid_o", valid_o, valid_hist[2]);
         if (valid_o === 1'b1)
         begin
            exp_v = exp_q.pop_front();
            assert (result_o === exp_v) else report_mismatch("result_o", result_o, exp_v);
            items_checked++;
         end
      end
   end

   ////////////////////
   // Stimulus

   initial
   begin
      int         amts[3];
      logic [4:0] imms[3];
      amts      = '{0, 1, 7};
      imms      = '{5'h13, 5'h10, 5'h0B};
      rst_i     = 1'b0;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = '0;
      pwdata_i  = '0;
      valid_i   = 1'b0;
      vs1_i     = '0;
      vs2_i     = '0;
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b1;

      // Reset values and register access
      assert (valid_o === 1'b0) else report_mismatch("valid_o", valid_o, 1'b0);
      apb_read(`REG_CTRL, 32'd0, 1'b0);
      apb_read(`REG_XDATA, 32'd0, 1'b0);
      apb_read(`REG_IMM, 32'd0, 1'b0);
      apb_write(`REG_CTRL, 32'hFFFF_FFFF, 1'b0);
      apb_read(`REG_CTRL, make_ctrl(3'h7, 2'h3, 2'h3, 1'b1, 1'b1, 3'h7), 1'b0);
      apb_write(`REG_XDATA, 32'hDEAD_BEEF, 1'b0);
      apb_read(`REG_XDATA, 32'hDEAD_BEEF, 1'b0);
      apb_write(`REG_IMM, 32'hFFFF_FFF5, 1'b0);
      apb_read(`REG_IMM, 32'h0000_0015, 1'b0);
      apb_write(4'hC, 32'h1234_5678, 1'b1);
      apb_read(4'hC, 32'd0, 1'b1);
      apb_read(`REG_CTRL, make_ctrl(3'h7, 2'h3, 2'h3, 1'b1, 1'b1, 3'h7), 1'b0);
      apb_read(`REG_XDATA, 32'hDEAD_BEEF, 1'b0);
      apb_read(`REG_IMM, 32'h0000_0015, 1'b0);

      // Every opcode at every width with the vector source
      for (int s = 0; s < 4; s++)
         for (int op = 0; op < 8; op++)
            run_config(make_ctrl(op[2:0], s[1:0], VEC, 1'b0, 1'b0, 3'd0), 5);

      // Scalar and immediate sources
      for (int s = 0; s < 3; s++)
      begin
         apb_write(`REG_XDATA, $random(seed), 1'b0);
         run_config(make_ctrl(ADD, s[1:0], XDATA, 1'b0, 1'b0, 3'd0), 4);
         run_config(make_ctrl(SUB, s[1:0], XDATA, 1'b0, 1'b0, 3'd0), 4);
         run_config(make_ctrl(XOR, s[1:0], XDATA, 1'b0, 1'b0, 3'd0), 4);
      end
      foreach (imms[i])
      begin
         apb_write(`REG_IMM, {27'd0, imms[i]}, 1'b0);
         for (int s = 0; s < 3; s++)
         begin
            run_config(make_ctrl(ADD, s[1:0], IMM, 1'b0, 1'b0, 3'd0), 3);
            run_config(make_ctrl(SUB, s[1:0], IMM, 1'b0, 1'b0, 3'd0), 3);
         end
      end

      // Lane slide up and down
      for (int dn = 0; dn < 2; dn++)
         foreach (amts[a])
            for (int s = 0; s < 3; s++)
               run_config(make_ctrl(ADD, s[1:0], VEC, 1'b1, dn[0], amts[a][2:0]), 3);
      run_config(make_ctrl(OR, SEW16, VEC, 1'b0, 1'b1, 3'd5), 3);

      // Reprogramming while items are in flight
      run_config(make_ctrl(SUB, SEW8, VEC, 1'b0, 1'b0, 3'd0), 3);
      fork
         apb_write(`REG_CTRL, make_ctrl(XOR, SEW32, IMM, 1'b1, 1'b1, 3'd3), 1'b0);
         drive_burst(5);
      join
      apb_write(`REG_CTRL, make_ctrl(ADD, SEW16, XDATA, 1'b1, 1'b0, 3'd2), 1'b0);
      fork
         apb_write(`REG_XDATA, 32'h8001_7FFF, 1'b0);
         drive_burst(5);
      join

      while (items_checked != items_sent)
         @(negedge clk_i);
      repeat (4) @(negedge clk_i);                      // Nothing extra may come out
      $display("TB PASSED");
      $finish;
   end

endmodule
